//--- common/game_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and debug page encodings shared by the game glue blocks
// Page and item values follow the debug_bus bit layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package game_pkg;

    // Data and status byte width
    localparam int BYTE_W = 8;

    // PROM download address from the loader
    localparam int PROG_AW = 16;

    // Decryption key table, 8 KB
    localparam int KEY_AW = 13;

    // Header offsets decoded from the loader address
    localparam int HDR_AW = 5;

    // Debug page, debug_bus[7:6]
    typedef enum logic [1:0] {
        PAGE_GAME  = 2'd0,
        PAGE_VIDEO = 2'd1,
        PAGE_MAIN  = 2'd2,
        PAGE_NONE  = 2'd3
    } st_page_e;

    // Item inside the game page, debug_bus[1:0]
    typedef enum logic [1:0] {
        ITEM_TILE_BANK = 2'd0,
        ITEM_GAME_ID   = 2'd1,
        ITEM_FLAGS     = 2'd2,
        ITEM_SOUND     = 2'd3
    } st_item_e;

endpackage

`default_nettype wire

//--- list.f
common/game_pkg.sv
src/header_regs.sv
src/xram_mapper.sv
src/prom_router.sv
src/status_mux.sv
src/game_glue.sv
sim/tb_clock.sv
sim/game_glue_properties.sv
sim/game_glue_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the game_glue testbench with Verilator, output in sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f list.f --top-module game_glue_tb -o game_glue_sim

status=0
./obj_dir/game_glue_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- sim/game_glue_properties.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound to game_glue, checked on every rising edge outside reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module game_glue_properties #(
    parameter logic [3:0] MCU_START = 4'hA
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         prom_we,
    input logic                         fd1094_en,
    input logic [game_pkg::PROG_AW-1:0] prog_addr,
    input logic                         mcu_prog_we,
    input logic                         lvbl,
    input logic [8:0]                   vrender,
    input logic                         gfx_cs,
    input logic                         main_rnw,
    input logic                         xram_we
);
    timeunit 1ns;
    timeprecision 100ps;
    import game_pkg::*;

    logic key_wr;

    // Key table write as seen from the top-level pins
    assign key_wr = prom_we && fd1094_en && (prog_addr[PROG_AW-1:PROG_AW-4] < MCU_START);

    a_one_destination: assert property (@(posedge clk) disable iff (rst)
        !(key_wr && mcu_prog_we))
        else $error("PROM byte went to the key table and the MCU at once");

    a_gfx_window: assert property (@(posedge clk) disable iff (rst)
        gfx_cs == (lvbl || (vrender == 9'd0) || vrender[8]))
        else $error("gfx_cs outside its blanking and line rule");

    a_write_enable: assert property (@(posedge clk) disable iff (rst)
        xram_we == !main_rnw)
        else $error("xram_we is not the inverse of main_rnw");

endmodule

bind game_glue game_glue_properties #(.MCU_START(MCU_START)) i_game_glue_properties (
    .clk         (clk),
    .rst         (rst),
    .prom_we     (prom_we),
    .fd1094_en   (fd1094_en),
    .prog_addr   (prog_addr),
    .mcu_prog_we (mcu_prog_we),
    .lvbl        (lvbl),
    .vrender     (vrender),
    .gfx_cs      (gfx_cs),
    .main_rnw    (main_rnw),
    .xram_we     (xram_we)
);

`default_nettype wire

//--- sim/game_glue_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random stimulus on game_glue against a model kept in the testbench
// Inputs change 1 ns after the rising edge, outputs sampled after that
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module game_glue_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import game_pkg::*;

    localparam logic [3:0] MCU_START     = 4'hA;
    localparam int         VRAMW         = 19;
    localparam int         MA_W          = VRAMW - 2;
    localparam int         N_ITER        = 200;
    localparam int         RESET_TIMEOUT = 50;

    logic clk;
    logic rst;
    logic header, ioctl_wr, prom_we;
    logic [HDR_AW-1:0] ioctl_addr;
    logic [BYTE_W-1:0] ioctl_dout, prog_data;
    logic [PROG_AW-1:0] prog_addr;
    logic fd1094_en, mcu_en;
    logic [BYTE_W-1:0] game_id;
    logic ram_cs, vram_cs, main_rnw, uds_n, lds_n;
    logic [VRAMW-2:1] main_addr;
    logic xram_cs, xram_we;
    logic [1:0] xram_dsn;
    logic [VRAMW-1:1] xram_addr;
    logic [KEY_AW-1:0] key_addr;
    logic [BYTE_W-1:0] key_data;
    logic mcu_prog_we;
    logic [11:0] mcu_prog_addr;
    logic [BYTE_W-1:0] mcu_prog_data;
    logic [BYTE_W-1:0] debug_bus, st_video, st_main, tile_bank, sndmap_dout;
    logic vid16_en, vdp_en, lvbl;
    logic [8:0] vrender;
    logic [BYTE_W-1:0] st_dout;
    logic gfx_cs;

    // Model state
    logic m_fd1094_en;
    logic m_mcu_en;
    logic [BYTE_W-1:0] m_game_id;
    logic [BYTE_W-1:0] model_key [2 ** KEY_AW];
    logic [KEY_AW-1:0] key_written [$];

    int errors;
    int tests_failed;
    bit reset_ok;

    tb_clock i_tb_clock (.clk(clk), .rst(rst));

    game_glue #(.MCU_START(MCU_START), .VRAMW(VRAMW)) i_game_glue (.*);

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // Offsets 0x11, 0x13 and 0x18, only on a write with header high
    task automatic update_header_model();
        if (header && ioctl_wr) begin
            if (ioctl_addr == 5'h11) m_fd1094_en = ioctl_dout[0];
            if (ioctl_addr == 5'h13) m_mcu_en = ioctl_dout[0];
            if (ioctl_addr == 5'h18) m_game_id = ioctl_dout;
        end
    endtask

    task automatic write_header(input logic [HDR_AW-1:0] addr, input logic [7:0] data);
        header = 1'b1;
        ioctl_wr = 1'b1;
        ioctl_addr = addr;
        ioctl_dout = data;
        update_header_model();
        next_cycle();
        header = 1'b0;
        ioctl_wr = 1'b0;
    endtask

    task automatic wait_reset(output bit ok);
        ok = 1'b0;
        for (int i = 0; i < RESET_TIMEOUT; i++) begin
            @(posedge clk);
            if (!rst) begin
                ok = 1'b1;
                break;
            end
        end
        #1;
    endtask

    function automatic logic [7:0] expected_status();
        logic [7:0] result;
        logic [7:0] flags;
        flags = {vid16_en, vdp_en, 4'b0000, m_mcu_en, m_fd1094_en};
        case (debug_bus[7:6])
            2'd0: begin
                case (debug_bus[1:0])
                    2'd0:    result = tile_bank;
                    2'd1:    result = m_game_id;
                    2'd2:    result = flags;
                    default: result = sndmap_dout;
                endcase
            end
            2'd1:    result = st_video;
            2'd2:    result = st_main;
            default: result = 8'h00;
        endcase
        return result;
    endfunction

    task automatic test_header(input int errs_before);
        int errs;
        errs = errs_before;
        if (fd1094_en !== 1'b0) report_mismatch("reset fd1094_en", 0, 32'(fd1094_en));
        if (mcu_en !== 1'b0) report_mismatch("reset mcu_en", 0, 32'(mcu_en));
        if (game_id !== 8'h00) report_mismatch("reset game_id", 0, 32'(game_id));
        for (int i = 0; i < N_ITER; i++) begin
            case ($urandom_range(3))
                0:       ioctl_addr = 5'h11;
                1:       ioctl_addr = 5'h13;
                2:       ioctl_addr = 5'h18;
                default: ioctl_addr = HDR_AW'($urandom);
            endcase
            header = ($urandom_range(7) != 0);
            ioctl_wr = ($urandom_range(3) != 0);
            ioctl_dout = 8'($urandom);
            update_header_model();
            next_cycle();
            if (fd1094_en !== m_fd1094_en)
                report_mismatch("header fd1094_en", 32'(m_fd1094_en), 32'(fd1094_en));
            if (mcu_en !== m_mcu_en)
                report_mismatch("header mcu_en", 32'(m_mcu_en), 32'(mcu_en));
            if (game_id !== m_game_id)
                report_mismatch("header game_id", 32'(m_game_id), 32'(game_id));
        end
        header = 1'b0;
        ioctl_wr = 1'b0;
        finish_test("header_capture", errs);
    endtask

    task automatic test_xram();
        int errs;
        int sel;
        logic [VRAMW-1:1] exp_addr;
        logic [1:0] exp_dsn;
        errs = errors;
        for (int i = 0; i < N_ITER; i++) begin
            sel = int'($urandom_range(2));
            ram_cs = (sel == 1);
            vram_cs = (sel == 2);
            main_addr = MA_W'($urandom);
            main_rnw = 1'($urandom);
            uds_n = 1'($urandom);
            lds_n = 1'($urandom);
            #1;
            // Region bit on top, then 13 word bits for RAM and 15 for VRAM
            exp_addr = {ram_cs, main_addr};
            if (ram_cs) exp_addr[VRAMW-2:14] = '0;
            if (vram_cs) exp_addr[VRAMW-2:16] = '0;
            exp_dsn = {uds_n | main_rnw, lds_n | main_rnw};
            if (xram_cs !== (ram_cs | vram_cs))
                report_mismatch("xram_cs", 32'(ram_cs | vram_cs), 32'(xram_cs));
            if (xram_we !== !main_rnw)
                report_mismatch("xram_we", 32'(!main_rnw), 32'(xram_we));
            if (xram_dsn !== exp_dsn)
                report_mismatch("xram_dsn", 32'(exp_dsn), 32'(xram_dsn));
            if (sel != 0 && xram_addr !== exp_addr)
                report_mismatch("xram_addr", 32'(exp_addr), 32'(xram_addr));
            next_cycle();
        end
        ram_cs = 1'b0;
        vram_cs = 1'b0;
        finish_test("xram_mapping", errs);
    endtask

    task automatic test_prom();
        int errs;
        logic [3:0] nib;
        logic [KEY_AW-1:0] kaddr;
        logic [11:0] exp_rel;
        logic exp_we;
        errs = errors;
        for (int round = 0; round < 6; round++) begin
            // First round always has both destinations open
            write_header(5'h11, (round == 0) ? 8'h01 : 8'($urandom));
            write_header(5'h13, (round == 0) ? 8'h01 : 8'($urandom));
            for (int i = 0; i < 40; i++) begin
                if (1'($urandom))
                    nib = 4'($urandom_range(32'(MCU_START) - 1));
                else
                    nib = 4'($urandom_range(15, 32'(MCU_START)));
                // Six random bits twice, so all offset bits toggle and addresses repeat
                prog_addr = {nib, {2{6'($urandom_range(63))}}};
                prog_data = 8'($urandom);
                prom_we = ($urandom_range(7) != 0);
                #1;
                exp_we = prom_we && m_mcu_en && (nib >= MCU_START);
                exp_rel = 12'(32'(prog_addr) - 32'(MCU_START) * 4096);
                if (mcu_prog_we !== exp_we)
                    report_mismatch("mcu_prog_we", 32'(exp_we), 32'(mcu_prog_we));
                if (exp_we && mcu_prog_addr !== exp_rel)
                    report_mismatch("mcu_prog_addr", 32'(exp_rel), 32'(mcu_prog_addr));
                if (exp_we && mcu_prog_data !== prog_data)
                    report_mismatch("mcu_prog_data", 32'(prog_data), 32'(mcu_prog_data));
                if (prom_we && m_fd1094_en && nib < MCU_START) begin
                    model_key[prog_addr[KEY_AW-1:0]] = prog_data;
                    key_written.push_back(prog_addr[KEY_AW-1:0]);
                end
                next_cycle();
            end
            prom_we = 1'b0;
            for (int i = 0; i < 16 && key_written.size() > 0; i++) begin
                kaddr = key_written[$urandom_range(key_written.size() - 1)];
                key_addr = kaddr;
                next_cycle();
                if (key_data !== model_key[kaddr])
                    report_mismatch("key_data", 32'(model_key[kaddr]), 32'(key_data));
            end
        end
        finish_test("prom_routing", errs);
    endtask

    task automatic test_status();
        int errs;
        logic [7:0] exp;
        errs = errors;
        for (int i = 0; i < N_ITER; i++) begin
            debug_bus = 8'($urandom);
            st_video = 8'($urandom);
            st_main = 8'($urandom);
            tile_bank = 8'($urandom);
            sndmap_dout = 8'($urandom);
            vid16_en = 1'($urandom);
            vdp_en = 1'($urandom);
            exp = expected_status();
            next_cycle();
            if (st_dout !== exp) report_mismatch("st_dout", 32'(exp), 32'(st_dout));
        end
        finish_test("status_select", errs);
    endtask

    task automatic test_gfx();
        int errs;
        logic exp;
        errs = errors;
        for (int i = 0; i < N_ITER; i++) begin
            lvbl = 1'($urandom);
            case ($urandom_range(3))
                0:       vrender = 9'd0;
                1:       vrender = 9'd255;
                2:       vrender = 9'd256;
                default: vrender = 9'($urandom);
            endcase
            #1;
            exp = lvbl || (vrender == 9'd0) || vrender[8];
            if (gfx_cs !== exp) report_mismatch("gfx_cs", 32'(exp), 32'(gfx_cs));
            next_cycle();
        end
        finish_test("gfx_window", errs);
    endtask

    initial begin
        void'($urandom(32'hb6c9_66c4));
        header = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        prom_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        ram_cs = 1'b0;
        vram_cs = 1'b0;
        main_addr = '0;
        main_rnw = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        key_addr = '0;
        // Video page with a nonzero byte, st_dout has to stay 0 in reset
        debug_bus = 8'h40;
        st_video = 8'ha5;
        st_main = '0;
        tile_bank = '0;
        sndmap_dout = '0;
        vid16_en = 1'b0;
        vdp_en = 1'b0;
        lvbl = 1'b0;
        vrender = '0;
        m_fd1094_en = 1'b0;
        m_mcu_en = 1'b0;
        m_game_id = '0;
        errors = 0;
        tests_failed = 0;
        next_cycle();
        if (st_dout !== 8'h00) report_mismatch("reset st_dout", 0, 32'(st_dout));
        debug_bus = '0;
        st_video = '0;
        wait_reset(reset_ok);
        if (!reset_ok) begin
            $display("reset never released within %0d cycles", RESET_TIMEOUT);
            $display("=== FAIL ===");
        end else begin
            // Header test also counts the in-reset check above
            test_header(0);
            test_xram();
            test_prom();
            test_status();
            test_gfx();
            $display("tests: 5, failed: %0d, errors: %0d", tests_failed, errors);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running 20 ns clock, reset high through the first three edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Released just after an edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- src/game_glue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Glue between loader, main CPU bus, external RAM and debug port
// No back-pressure, every strobe is taken in its own cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module game_glue #(
    parameter logic [3:0] MCU_START = 4'hA,
    parameter int          VRAMW     = 19
) (
    input  logic                         clk,
    input  logic                         rst,
    // Loader
    input  logic                         header,
    input  logic                         ioctl_wr,
    input  logic [game_pkg::HDR_AW-1:0]  ioctl_addr,
    input  logic [game_pkg::BYTE_W-1:0]  ioctl_dout,
    input  logic                         prom_we,
    input  logic [game_pkg::PROG_AW-1:0] prog_addr,
    input  logic [game_pkg::BYTE_W-1:0]  prog_data,
    // Game configuration
    output logic                         fd1094_en,
    output logic                         mcu_en,
    output logic [game_pkg::BYTE_W-1:0]  game_id,
    // Main CPU bus
    input  logic                         ram_cs,
    input  logic                         vram_cs,
    input  logic [VRAMW-2:1]             main_addr,
    input  logic                         main_rnw,
    input  logic                         uds_n,
    input  logic                         lds_n,
    // External RAM
    output logic                         xram_cs,
    output logic                         xram_we,
    output logic [1:0]                   xram_dsn,
    output logic [VRAMW-1:1]             xram_addr,
    // Decoder key port
    input  logic [game_pkg::KEY_AW-1:0]  key_addr,
    output logic [game_pkg::BYTE_W-1:0]  key_data,
    // MCU program load
    output logic                         mcu_prog_we,
    output logic [11:0]                  mcu_prog_addr,
    output logic [game_pkg::BYTE_W-1:0]  mcu_prog_data,
    // Status and video
    input  logic [game_pkg::BYTE_W-1:0]  debug_bus,
    input  logic [game_pkg::BYTE_W-1:0]  st_video,
    input  logic [game_pkg::BYTE_W-1:0]  st_main,
    input  logic [game_pkg::BYTE_W-1:0]  tile_bank,
    input  logic [game_pkg::BYTE_W-1:0]  sndmap_dout,
    input  logic                         vid16_en,
    input  logic                         vdp_en,
    input  logic                         lvbl,
    input  logic [8:0]                   vrender,
    output logic [game_pkg::BYTE_W-1:0]  st_dout,
    output logic                         gfx_cs
);

    header_regs i_header_regs (
        .clk        (clk),
        .rst        (rst),
        .header     (header),
        .ioctl_wr   (ioctl_wr),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .fd1094_en  (fd1094_en),
        .mcu_en     (mcu_en),
        .game_id    (game_id)
    );

    xram_mapper #(
        .VRAMW (VRAMW)
    ) i_xram_mapper (
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .main_rnw  (main_rnw),
        .uds_n     (uds_n),
        .lds_n     (lds_n),
        .main_addr (main_addr),
        .xram_cs   (xram_cs),
        .xram_we   (xram_we),
        .xram_dsn  (xram_dsn),
        .xram_addr (xram_addr)
    );

    // Header enables gate both PROM destinations
    prom_router #(
        .MCU_START (MCU_START)
    ) i_prom_router (
        .clk           (clk),
        .prom_we       (prom_we),
        .fd1094_en     (fd1094_en),
        .mcu_en        (mcu_en),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .key_addr      (key_addr),
        .key_data      (key_data),
        .mcu_prog_we   (mcu_prog_we),
        .mcu_prog_addr (mcu_prog_addr),
        .mcu_prog_data (mcu_prog_data)
    );

    status_mux i_status_mux (
        .clk         (clk),
        .rst         (rst),
        .debug_bus   (debug_bus),
        .st_video    (st_video),
        .st_main     (st_main),
        .tile_bank   (tile_bank),
        .sndmap_dout (sndmap_dout),
        .game_id     (game_id),
        .vid16_en    (vid16_en),
        .vdp_en      (vdp_en),
        .fd1094_en   (fd1094_en),
        .mcu_en      (mcu_en),
        .lvbl        (lvbl),
        .vrender     (vrender),
        .st_dout     (st_dout),
        .gfx_cs      (gfx_cs)
    );

endmodule

`default_nettype wire

//--- src/header_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Captures per-game settings from the ROM header download
// Only the low HDR_AW address bits are decoded, so offsets alias
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module header_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         header,
    input  logic                         ioctl_wr,
    input  logic [game_pkg::HDR_AW-1:0]  ioctl_addr,
    input  logic [game_pkg::BYTE_W-1:0]  ioctl_dout,
    output logic                         fd1094_en,
    output logic                         mcu_en,
    output logic [game_pkg::BYTE_W-1:0]  game_id
);
    import game_pkg::*;

    // Header byte offsets
    localparam logic [HDR_AW-1:0] OFS_DECODER = HDR_AW'('h11);
    localparam logic [HDR_AW-1:0] OFS_MCU     = HDR_AW'('h13);
    localparam logic [HDR_AW-1:0] OFS_GAME_ID = HDR_AW'('h18);

    logic hdr_wr;

    assign hdr_wr = header && ioctl_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            fd1094_en <= 1'b0;
            mcu_en    <= 1'b0;
            game_id   <= '0;
        end else if (hdr_wr) begin
            // Enables take bit 0 only
            if (ioctl_addr == OFS_DECODER) begin
                fd1094_en <= ioctl_dout[0];
            end
            if (ioctl_addr == OFS_MCU) begin
                mcu_en <= ioctl_dout[0];
            end
            if (ioctl_addr == OFS_GAME_ID) begin
                game_id <= ioctl_dout;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/prom_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PROM bytes below MCU_START fill the key table, the rest go to the MCU
// Key reads return one cycle after the address, the table has no reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module prom_router #(
    parameter logic [3:0] MCU_START = 4'hA
) (
    input  logic                         clk,
    input  logic                         prom_we,
    input  logic                         fd1094_en,
    input  logic                         mcu_en,
    input  logic [game_pkg::PROG_AW-1:0] prog_addr,
    input  logic [game_pkg::BYTE_W-1:0]  prog_data,
    input  logic [game_pkg::KEY_AW-1:0]  key_addr,
    output logic [game_pkg::BYTE_W-1:0]  key_data,
    output logic                         mcu_prog_we,
    output logic [11:0]                  mcu_prog_addr,
    output logic [game_pkg::BYTE_W-1:0]  mcu_prog_data
);
    import game_pkg::*;

    localparam int KEY_DEPTH = 2 ** KEY_AW;

    // Byte address where MCU space begins
    localparam logic [PROG_AW-1:0] MCU_BASE = {MCU_START, {(PROG_AW - 4){1'b0}}};

    logic [BYTE_W-1:0] key_mem [KEY_DEPTH];

    logic              mcu_win;
    logic              key_we;
    logic [KEY_AW-1:0] key_wr_addr;

    // Windows are disjoint, boundary nibble belongs to the MCU
    assign mcu_win = prog_addr[PROG_AW-1:PROG_AW-4] >= MCU_START;

    assign key_we      = prom_we && fd1094_en && !mcu_win;
    assign mcu_prog_we = prom_we && mcu_en && mcu_win;

    assign key_wr_addr = prog_addr[KEY_AW-1:0];

    // Offset from the start of MCU space
    assign mcu_prog_addr = 12'(prog_addr - MCU_BASE);
    assign mcu_prog_data = prog_data;

    always_ff @(posedge clk) begin
        if (key_we) begin
            key_mem[key_wr_addr] <= prog_data;
        end
    end

    // Decoder read port
    always_ff @(posedge clk) begin
        key_data <= key_mem[key_addr];
    end

endmodule

`default_nettype wire

//--- src/status_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug status byte selected by debug_bus, one cycle late
// gfx_cs is combinational from blanking and the render line
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module status_mux (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [game_pkg::BYTE_W-1:0] debug_bus,
    input  logic [game_pkg::BYTE_W-1:0] st_video,
    input  logic [game_pkg::BYTE_W-1:0] st_main,
    input  logic [game_pkg::BYTE_W-1:0] tile_bank,
    input  logic [game_pkg::BYTE_W-1:0] sndmap_dout,
    input  logic [game_pkg::BYTE_W-1:0] game_id,
    input  logic                        vid16_en,
    input  logic                        vdp_en,
    input  logic                        fd1094_en,
    input  logic                        mcu_en,
    input  logic                        lvbl,
    input  logic [8:0]                  vrender,
    output logic [game_pkg::BYTE_W-1:0] st_dout,
    output logic                        gfx_cs
);
    import game_pkg::*;

    st_page_e          page;
    st_item_e          item;
    logic [BYTE_W-1:0] flags;
    logic [BYTE_W-1:0] st_sel;

    assign page = st_page_e'(debug_bus[BYTE_W-1:BYTE_W-2]);
    assign item = st_item_e'(debug_bus[1:0]);

    assign flags = {vid16_en, vdp_en, 4'd0, mcu_en, fd1094_en};

    always_comb begin
        st_sel = '0;
        case (page)
            PAGE_GAME: begin
                case (item)
                    ITEM_TILE_BANK: st_sel = tile_bank;
                    ITEM_GAME_ID:   st_sel = game_id;
                    ITEM_FLAGS:     st_sel = flags;
                    ITEM_SOUND:     st_sel = sndmap_dout;
                    default:        st_sel = '0;
                endcase
            end
            PAGE_VIDEO: st_sel = st_video;
            PAGE_MAIN:  st_sel = st_main;
            default:    st_sel = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_dout <= '0;
        end else begin
            st_dout <= st_sel;
        end
    end

    // Fetch during vertical blank, on line 0 and past line 255
    assign gfx_cs = lvbl || (vrender == 9'd0) || vrender[8];

endmodule

`default_nettype wire

//--- src/xram_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Work RAM and VRAM share one external RAM, work RAM in the upper half
// Each region wraps within its own size, 16 KB RAM and 64 KB VRAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xram_mapper #(
    parameter int VRAMW = 19
) (
    input  logic             ram_cs,
    input  logic             vram_cs,
    input  logic             main_rnw,
    input  logic             uds_n,
    input  logic             lds_n,
    input  logic [VRAMW-2:1] main_addr,
    output logic             xram_cs,
    output logic             xram_we,
    output logic [1:0]       xram_dsn,
    output logic [VRAMW-1:1] xram_addr
);

    // Word address bits kept per region
    localparam int RAM_WB  = 13;
    localparam int VRAM_WB = 15;

    // Masks clear the bits between the region's top and the region bit
    localparam logic [VRAMW-1:1] RAM_MASK =
        {1'b1, {(VRAMW - 2 - RAM_WB){1'b0}}, {RAM_WB{1'b1}}};
    localparam logic [VRAMW-1:1] VRAM_MASK =
        {1'b1, {(VRAMW - 2 - VRAM_WB){1'b0}}, {VRAM_WB{1'b1}}};

    logic [VRAMW-1:1] raw_addr;

    // Region bit sits just above the CPU word address
    assign raw_addr = {ram_cs, main_addr};

    always_comb begin
        xram_addr = raw_addr;
        if (ram_cs) begin
            xram_addr = xram_addr & RAM_MASK;
        end
        if (vram_cs) begin
            xram_addr = xram_addr & VRAM_MASK;
        end
    end

    assign xram_cs = ram_cs | vram_cs;
    assign xram_we = ~main_rnw;

    // Reads keep both strobes inactive
    assign xram_dsn = {uds_n, lds_n} | {2{main_rnw}};

endmodule

`default_nettype wire
